//--- cpuPkg.sv
package cpuPkg;

  typedef logic [31:0] instrT;
  typedef logic [31:0] wordT;
  typedef logic [4:0]  regAddrT;
  typedef logic [5:0]  opcodeT;

  // Arithmetic group
  localparam opcodeT opAdd      = 6'h00;
  localparam opcodeT opSub      = 6'h01;
  localparam opcodeT opMul      = 6'h02;

  // Memory group
  localparam opcodeT opLdb      = 6'h10;
  localparam opcodeT opLdw      = 6'h11;
  localparam opcodeT opStb      = 6'h12;
  localparam opcodeT opStw      = 6'h13;

  // System group
  localparam opcodeT opMovRm1   = 6'h20;
  localparam opcodeT opTlbWrite = 6'h21;
  localparam opcodeT opIret     = 6'h22;

  // Control flow group
  localparam opcodeT opBeq      = 6'h30;
  localparam opcodeT opJump     = 6'h31;

  localparam int ctrlWidth   = 12;
  localparam int bitRegDst   = 0;
  localparam int bitBranch   = 1;
  localparam int bitMemRead  = 2;
  localparam int bitMemToReg = 3;
  localparam int bitMemWrite = 4;
  localparam int bitAluSrc   = 5;
  localparam int bitRegWrite = 6;
  localparam int bitJump     = 7;
  localparam int bitWord     = 8;
  localparam int bitTlbWrite = 9;
  localparam int bitIret     = 10;
  localparam int bitIgnoreOp2 = 11;

  function automatic opcodeT opcodeOf(instrT instr);
    return instr[31:26];
  endfunction

  function automatic regAddrT rsOf(instrT instr);
    return instr[25:21];
  endfunction

  function automatic regAddrT rtOf(instrT instr);
    return instr[20:16];
  endfunction

  function automatic regAddrT rdOf(instrT instr);
    return instr[15:11];
  endfunction

  function automatic wordT signExtImm(instrT instr);
    return {{16{instr[15]}}, instr[15:0]};
  endfunction

endpackage

//--- controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder import cpuPkg::*; (
  input  opcodeT opcode,
  input  logic   flushCtrlBits,
  output logic   regDst,
  output logic   branch,
  output logic   memRead,
  output logic   memToReg,
  output logic   memWrite,
  output logic   aluSrc,
  output logic   regWrite,
  output logic   jump,
  output logic   word,
  output logic   tlbWrite,
  output logic   iret,
  output logic   ignoreOp2
);

  logic [ctrlWidth-1:0] ctrl;

  always_comb begin
    ctrl = '0;
    if (!flushCtrlBits) begin // Bubble keeps everything low
      case (opcode)
        opAdd,
        opSub,
        opMul: begin
          ctrl[bitRegDst]   = 1'b1;
          ctrl[bitRegWrite] = 1'b1;
        end
        opMovRm1: begin
          ctrl[bitRegDst]    = 1'b1;
          ctrl[bitRegWrite]  = 1'b1;
          ctrl[bitIgnoreOp2] = 1'b1; // Second operand forced to -1 in execute
        end
        opLdb: begin
          ctrl[bitMemRead]  = 1'b1;
          ctrl[bitMemToReg] = 1'b1;
          ctrl[bitAluSrc]   = 1'b1;
          ctrl[bitRegWrite] = 1'b1;
        end
        opLdw: begin
          ctrl[bitMemRead]  = 1'b1;
          ctrl[bitMemToReg] = 1'b1;
          ctrl[bitAluSrc]   = 1'b1;
          ctrl[bitRegWrite] = 1'b1;
          ctrl[bitWord]     = 1'b1;
        end
        opStb: begin
          ctrl[bitMemWrite] = 1'b1;
          ctrl[bitAluSrc]   = 1'b1;
        end
        opStw: begin
          ctrl[bitMemWrite] = 1'b1;
          ctrl[bitAluSrc]   = 1'b1;
          ctrl[bitWord]     = 1'b1;
        end
        opTlbWrite: begin
          ctrl[bitTlbWrite] = 1'b1;
        end
        opIret: begin
          ctrl[bitIret] = 1'b1;
        end
        opBeq: begin
          ctrl[bitBranch] = 1'b1;
        end
        opJump: begin
          ctrl[bitJump] = 1'b1;
        end
        default: begin
          ctrl = '0; // Unknown opcode acts as a nop
        end
      endcase
    end
  end

  assign regDst    = ctrl[bitRegDst];
  assign branch    = ctrl[bitBranch];
  assign memRead   = ctrl[bitMemRead];
  assign memToReg  = ctrl[bitMemToReg];
  assign memWrite  = ctrl[bitMemWrite];
  assign aluSrc    = ctrl[bitAluSrc];
  assign regWrite  = ctrl[bitRegWrite];
  assign jump      = ctrl[bitJump];
  assign word      = ctrl[bitWord];
  assign tlbWrite  = ctrl[bitTlbWrite];
  assign iret      = ctrl[bitIret];
  assign ignoreOp2 = ctrl[bitIgnoreOp2];

endmodule

//--- registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuPkg::*; #(
  parameter int regCount = 32
) (
  input  logic    clk,
  input  logic    reset,
  input  regAddrT readAddr1,
  input  regAddrT readAddr2,
  input  logic    writeEnable,
  input  regAddrT writeAddr,
  input  wordT    writeData,
  output wordT    readData1,
  output wordT    readData2
);

  localparam int idxWidth = $clog2(regCount);

  wordT regs [regCount];

  // Register 0 and unimplemented indices are not backed by storage
  function automatic logic usable(regAddrT addr);
    return (addr != '0) && (int'(addr) < regCount);
  endfunction

  function automatic wordT readPort(regAddrT addr);
    wordT data;
    data = '0;
    if (usable(addr)) begin
      if (writeEnable && writeAddr == addr) begin
        data = writeData; // Write-through from write-back
      end else begin
        data = regs[addr[idxWidth-1:0]];
      end
    end
    return data;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && usable(writeAddr)) begin
      regs[writeAddr[idxWidth-1:0]] <= writeData;
    end
  end

  always_comb begin
    readData1 = readPort(readAddr1);
    readData2 = readPort(readAddr2);
  end

endmodule

//--- hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*; (
  input  regAddrT rs,
  input  regAddrT rt,
  input  logic    exMemRead,
  input  regAddrT exRt,
  input  logic    flush,
  output logic    stall,
  output logic    flushCtrlBits
);

  logic loadInEx;
  logic rsMatch;
  logic rtMatch;

  // Load in execute writing a real register
  assign loadInEx = exMemRead && (exRt != '0);

  assign rsMatch = (exRt == rs);
  assign rtMatch = (exRt == rt);

  // Dependent instruction must wait one cycle for the load data
  assign stall = loadInEx && (rsMatch || rtMatch);

  // Decoder sees a single kill condition
  assign flushCtrlBits = stall || flush;

endmodule

//--- idExRegister.sv
`timescale 1ns/1ps

module idExRegister import cpuPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    regDst,
  input  logic    branch,
  input  logic    memRead,
  input  logic    memToReg,
  input  logic    memWrite,
  input  logic    aluSrc,
  input  logic    regWrite,
  input  logic    jump,
  input  logic    word,
  input  logic    tlbWrite,
  input  logic    iret,
  input  logic    ignoreOp2,
  input  wordT    readData1,
  input  wordT    readData2,
  input  instrT   instruction,
  input  wordT    pcPlus4,
  output logic    exRegDst,
  output logic    exBranch,
  output logic    exMemRead,
  output logic    exMemToReg,
  output logic    exMemWrite,
  output logic    exAluSrc,
  output logic    exRegWrite,
  output logic    exJump,
  output logic    exWord,
  output logic    exTlbWrite,
  output logic    exIret,
  output logic    exIgnoreOp2,
  output wordT    exReadData1,
  output wordT    exReadData2,
  output wordT    exImmediate,
  output regAddrT exRs,
  output regAddrT exRt,
  output regAddrT exRd,
  output wordT    exPcPlus4
);

  logic [ctrlWidth-1:0] ctrlIn;
  logic [ctrlWidth-1:0] ctrlQ;

  // Bubbles arrive here already zeroed by the decoder
  assign ctrlIn = {ignoreOp2, iret, tlbWrite, word, jump, regWrite,
                   aluSrc, memWrite, memToReg, memRead, branch, regDst};

  always_ff @(posedge clk) begin
    if (reset) begin
      ctrlQ       <= '0;
      exReadData1 <= '0;
      exReadData2 <= '0;
      exImmediate <= '0;
      exRs        <= '0;
      exRt        <= '0;
      exRd        <= '0;
      exPcPlus4   <= '0;
    end else begin
      ctrlQ       <= ctrlIn;
      exReadData1 <= readData1;
      exReadData2 <= readData2;
      exImmediate <= signExtImm(instruction);
      exRs        <= rsOf(instruction);
      exRt        <= rtOf(instruction); // Also the load destination for hazards
      exRd        <= rdOf(instruction);
      exPcPlus4   <= pcPlus4;
    end
  end

  assign {exIgnoreOp2, exIret, exTlbWrite, exWord, exJump, exRegWrite,
          exAluSrc, exMemWrite, exMemToReg, exMemRead, exBranch, exRegDst} = ctrlQ;

endmodule

//--- decodeStage.sv
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; #(
  parameter int regCount = 32
) (
  input  logic    clk,
  input  logic    reset,
  input  instrT   instruction,
  input  wordT    pcPlus4,
  input  logic    wbWrite,
  input  regAddrT wbAddr,
  input  wordT    wbData,
  input  logic    flush,
  output logic    stall,
  output logic    exRegDst,
  output logic    exBranch,
  output logic    exMemRead,
  output logic    exMemToReg,
  output logic    exMemWrite,
  output logic    exAluSrc,
  output logic    exRegWrite,
  output logic    exJump,
  output logic    exWord,
  output logic    exTlbWrite,
  output logic    exIret,
  output logic    exIgnoreOp2,
  output wordT    exReadData1,
  output wordT    exReadData2,
  output wordT    exImmediate,
  output regAddrT exRs,
  output regAddrT exRt,
  output regAddrT exRd,
  output wordT    exPcPlus4
);

  opcodeT  opcode;
  regAddrT rs;
  regAddrT rt;
  logic    flushCtrlBits;
  wordT    readData1;
  wordT    readData2;
  logic    regDst, branch, memRead, memToReg, memWrite, aluSrc;
  logic    regWrite, jump, word, tlbWrite, iret, ignoreOp2;

  assign opcode = opcodeOf(instruction);
  assign rs     = rsOf(instruction);
  assign rt     = rtOf(instruction);

  controlDecoder u_controlDecoder (
    .opcode(opcode), .flushCtrlBits(flushCtrlBits),
    .regDst(regDst), .branch(branch), .memRead(memRead), .memToReg(memToReg),
    .memWrite(memWrite), .aluSrc(aluSrc), .regWrite(regWrite), .jump(jump),
    .word(word), .tlbWrite(tlbWrite), .iret(iret), .ignoreOp2(ignoreOp2)
  );

  registerFile #(.regCount(regCount)) u_registerFile (
    .clk(clk), .reset(reset), .readAddr1(rs), .readAddr2(rt),
    .writeEnable(wbWrite), .writeAddr(wbAddr), .writeData(wbData),
    .readData1(readData1), .readData2(readData2)
  );

  hazardUnit u_hazardUnit (
    .rs(rs), .rt(rt), .exMemRead(exMemRead), .exRt(exRt), // Fed back from ID/EX
    .flush(flush), .stall(stall), .flushCtrlBits(flushCtrlBits)
  );

  idExRegister u_idExRegister (
    .clk(clk), .reset(reset),
    .regDst(regDst), .branch(branch), .memRead(memRead), .memToReg(memToReg),
    .memWrite(memWrite), .aluSrc(aluSrc), .regWrite(regWrite), .jump(jump),
    .word(word), .tlbWrite(tlbWrite), .iret(iret), .ignoreOp2(ignoreOp2),
    .readData1(readData1), .readData2(readData2),
    .instruction(instruction), .pcPlus4(pcPlus4),
    .exRegDst(exRegDst), .exBranch(exBranch), .exMemRead(exMemRead),
    .exMemToReg(exMemToReg), .exMemWrite(exMemWrite), .exAluSrc(exAluSrc),
    .exRegWrite(exRegWrite), .exJump(exJump), .exWord(exWord),
    .exTlbWrite(exTlbWrite), .exIret(exIret), .exIgnoreOp2(exIgnoreOp2),
    .exReadData1(exReadData1), .exReadData2(exReadData2),
    .exImmediate(exImmediate), .exRs(exRs), .exRt(exRt), .exRd(exRd),
    .exPcPlus4(exPcPlus4)
  );

endmodule

//--- decodeStage_chk.sv
`timescale 1ns/1ps

module decodeStage_chk (
  input logic clk,
  input logic reset,
  input logic stall,
  input logic flush,
  input logic exRegDst,
  input logic exBranch,
  input logic exMemRead,
  input logic exMemToReg,
  input logic exMemWrite,
  input logic exAluSrc,
  input logic exRegWrite,
  input logic exJump,
  input logic exWord,
  input logic exTlbWrite,
  input logic exIret,
  input logic exIgnoreOp2
);

  logic [11:0] exCtrl;
  int          failCount = 0;

  assign exCtrl = {exRegDst, exBranch, exMemRead, exMemToReg, exMemWrite, exAluSrc,
                   exRegWrite, exJump, exWord, exTlbWrite, exIret, exIgnoreOp2};

  // Killed decode leaves a bubble in execute
  bubbleAfterKill: assert property (@(posedge clk) disable iff (reset)
    (stall || flush) |=> (exCtrl == '0)) else begin
    failCount++;
    $error("Control bits in execute not cleared after a stall or flush");
  end

  noLoadAndStore: assert property (@(posedge clk) disable iff (reset)
    !(exMemRead && exMemWrite)) else begin
    failCount++;
    $error("Load and store both active in execute");
  end

  quietAfterReset: assert property (@(posedge clk) reset |=> (exCtrl == '0)) else begin
    failCount++;
    $error("Control bits in execute not cleared by reset");
  end

endmodule

//--- decodeStage_tb.sv
`timescale 1ns/1ps

module decodeStage_tb import cpuPkg::*; ();

  localparam int regCount   = 16;
  localparam int cycleLimit = 2000; // Tests need about 110 cycles

  logic    clk;
  logic    reset;
  instrT   instruction;
  wordT    pcPlus4;
  logic    wbWrite;
  regAddrT wbAddr;
  wordT    wbData;
  logic    flush;
  logic    stall;
  logic    exRegDst, exBranch, exMemRead, exMemToReg, exMemWrite, exAluSrc;
  logic    exRegWrite, exJump, exWord, exTlbWrite, exIret, exIgnoreOp2;
  wordT    exReadData1, exReadData2, exImmediate, exPcPlus4;
  regAddrT exRs, exRt, exRd;

  integer  seed = 32'hac8c2386;
  int      cycles = 0;
  int      errorCount = 0;
  int      testErrors = 0;
  int      testCount = 0;
  wordT    refRegs [32];
  logic    mExMemRead; // Model of the load sitting in execute
  regAddrT mExRt;
  string   ctrlNames [12] = '{"exIgnoreOp2", "exIret", "exTlbWrite", "exWord", "exJump",
                              "exRegWrite", "exAluSrc", "exMemWrite", "exMemToReg",
                              "exMemRead", "exBranch", "exRegDst"};
  opcodeT  opList [16] = '{opAdd, opSub, opMul, opLdb, opLdw, opStb, opStw, opMovRm1,
                           opTlbWrite, opIret, opBeq, opJump,
                           6'h03, 6'h14, 6'h2f, 6'h3f}; // Last four are unlisted

  decodeStage #(.regCount(regCount)) u_dut (
    .clk(clk), .reset(reset), .instruction(instruction), .pcPlus4(pcPlus4),
    .wbWrite(wbWrite), .wbAddr(wbAddr), .wbData(wbData), .flush(flush), .stall(stall),
    .exRegDst(exRegDst), .exBranch(exBranch), .exMemRead(exMemRead),
    .exMemToReg(exMemToReg), .exMemWrite(exMemWrite), .exAluSrc(exAluSrc),
    .exRegWrite(exRegWrite), .exJump(exJump), .exWord(exWord),
    .exTlbWrite(exTlbWrite), .exIret(exIret), .exIgnoreOp2(exIgnoreOp2),
    .exReadData1(exReadData1), .exReadData2(exReadData2),
    .exImmediate(exImmediate), .exRs(exRs), .exRt(exRt), .exRd(exRd),
    .exPcPlus4(exPcPlus4)
  );

  bind decodeStage decodeStage_chk u_chk (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush),
    .exRegDst(exRegDst), .exBranch(exBranch), .exMemRead(exMemRead),
    .exMemToReg(exMemToReg), .exMemWrite(exMemWrite), .exAluSrc(exAluSrc),
    .exRegWrite(exRegWrite), .exJump(exJump), .exWord(exWord),
    .exTlbWrite(exTlbWrite), .exIret(exIret), .exIgnoreOp2(exIgnoreOp2)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycleLimit) begin
      $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Bit order regDst branch memRead memToReg memWrite aluSrc regWrite jump word tlbWrite
  // iret ignoreOp2
  function automatic logic [11:0] decodeRef(opcodeT op);
    case (op)
      opAdd, opSub, opMul: return 12'b1000_0010_0000;
      opMovRm1:            return 12'b1000_0010_0001;
      opLdb:               return 12'b0011_0110_0000;
      opLdw:               return 12'b0011_0110_1000;
      opStb:               return 12'b0000_1100_0000;
      opStw:               return 12'b0000_1100_1000;
      opTlbWrite:          return 12'b0000_0000_0100;
      opIret:              return 12'b0000_0000_0010;
      opBeq:               return 12'b0100_0000_0000;
      opJump:              return 12'b0000_0001_0000;
      default:             return 12'b0000_0000_0000;
    endcase
  endfunction

  function automatic wordT readRef(regAddrT addr);
    if (addr == '0 || int'(addr) >= regCount)
      return '0;
    if (wbWrite && wbAddr == addr)
      return wbData; // Write-through
    return refRegs[addr];
  endfunction

  function automatic instrT makeInstr(opcodeT op, regAddrT rs, regAddrT rt, logic [15:0] low);
    return {op, rs, rt, low};
  endfunction

  task automatic checkWord(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      errorCount++;
      testErrors++;
      $display("Fail %s expected %h got %h", name, exp, got);
    end
  endtask

  task automatic checkCtrl(logic [11:0] exp);
    logic [11:0] got;
    got = {exRegDst, exBranch, exMemRead, exMemToReg, exMemWrite, exAluSrc,
           exRegWrite, exJump, exWord, exTlbWrite, exIret, exIgnoreOp2};
    for (int i = 0; i < 12; i++) begin
      checkWord(ctrlNames[i], 32'(got[i]), 32'(exp[i]));
    end
  endtask

  task automatic endTest(string name);
    testCount++;
    if (testErrors == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d mismatches", name, testErrors);
    end
    testErrors = 0;
  endtask

  // Entered on a falling edge, returns on the next one
  task automatic runCycle(instrT instr, logic fl, logic wbW, regAddrT wbA, wordT wbD);
    logic [11:0] expCtrl;
    logic        expStall;
    wordT        expRead1;
    wordT        expRead2;
    wordT        pc;
    pc = $random(seed);
    instruction = instr;
    pcPlus4 = pc;
    flush = fl;
    wbWrite = wbW;
    wbAddr = wbA;
    wbData = wbD;
    expStall = mExMemRead && mExRt != '0 && (mExRt == instr[25:21] || mExRt == instr[20:16]);
    expCtrl = (expStall || fl) ? 12'h000 : decodeRef(instr[31:26]);
    expRead1 = readRef(instr[25:21]);
    expRead2 = readRef(instr[20:16]);
    #5;
    checkWord("stall", 32'(stall), 32'(expStall));
    @(negedge clk);
    checkCtrl(expCtrl);
    checkWord("exReadData1", exReadData1, expRead1);
    checkWord("exReadData2", exReadData2, expRead2);
    checkWord("exImmediate", exImmediate, {{16{instr[15]}}, instr[15:0]});
    checkWord("exRs", 32'(exRs), 32'(instr[25:21]));
    checkWord("exRt", 32'(exRt), 32'(instr[20:16]));
    checkWord("exRd", 32'(exRd), 32'(instr[15:11]));
    checkWord("exPcPlus4", exPcPlus4, pc);
    mExMemRead = expCtrl[9];
    mExRt = instr[20:16];
    if (wbW && wbA != '0 && int'(wbA) < regCount) begin
      refRegs[wbA] = wbD;
    end
  endtask

  initial begin
    instrT stalled;
    reset = 1'b1;
    instruction = '0;
    pcPlus4 = '0;
    wbWrite = 1'b0;
    wbAddr = '0;
    wbData = '0;
    flush = 1'b0;
    mExMemRead = 1'b0;
    mExRt = '0;
    foreach (refRegs[i]) begin
      refRegs[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    checkCtrl(12'h000);
    checkWord("stall", 32'(stall), 32'h0);
    endTest("reset");

    foreach (opList[i]) begin
      runCycle(makeInstr(opList[i], regAddrT'($random(seed)), '0, 16'($random(seed))),
               1'b0, 1'b0, '0, '0); // rt of zero keeps loads from stalling the next op
    end
    endTest("decode table");

    for (int i = 0; i < 32; i++) begin
      runCycle(makeInstr(6'h3f, '0, '0, 16'h0), 1'b0, 1'b1, regAddrT'(i), $random(seed));
    end
    for (int i = 0; i < 32; i += 2) begin
      runCycle(makeInstr(opAdd, regAddrT'(i), regAddrT'(i + 1), 16'h0), 1'b0, 1'b0, '0, '0);
    end
    runCycle(makeInstr(opAdd, 5'd5, 5'd6, 16'h0), 1'b0, 1'b1, 5'd5, 32'hcafe_0005);
    runCycle(makeInstr(opSub, 5'd5, 5'd6, 16'h0), 1'b0, 1'b1, 5'd6, 32'hbeef_0006);
    runCycle(makeInstr(opAdd, 5'd20, 5'd0, 16'h0), 1'b0, 1'b1, 5'd20, 32'h1234_5678);
    endTest("register file");

    runCycle(makeInstr(opLdw, 5'd1, 5'd7, 16'h0010), 1'b0, 1'b0, '0, '0);
    stalled = makeInstr(opAdd, 5'd7, 5'd2, 16'h3800);
    runCycle(stalled, 1'b0, 1'b0, '0, '0);
    runCycle(stalled, 1'b0, 1'b0, '0, '0); // Held by the environment
    runCycle(makeInstr(opLdb, 5'd2, 5'd9, 16'hfffc), 1'b0, 1'b0, '0, '0);
    stalled = makeInstr(opStw, 5'd3, 5'd9, 16'h0008);
    runCycle(stalled, 1'b0, 1'b0, '0, '0);
    runCycle(stalled, 1'b0, 1'b0, '0, '0);
    endTest("load-use stall");

    runCycle(makeInstr(opBeq, 5'd1, 5'd2, 16'h0004), 1'b1, 1'b0, '0, '0);
    runCycle(makeInstr(opJump, 5'd0, 5'd0, 16'h0040), 1'b0, 1'b0, '0, '0);
    runCycle(makeInstr(opLdw, 5'd4, 5'd10, 16'h0000), 1'b1, 1'b0, '0, '0);
    runCycle(makeInstr(opAdd, 5'd10, 5'd1, 16'h0000), 1'b0, 1'b0, '0, '0);
    endTest("branch flush");

    runCycle(makeInstr(opLdw, 5'd4, 5'd5, 16'h8000), 1'b0, 1'b0, '0, '0);
    for (int i = 0; i < 24; i++) begin
      runCycle($random(seed), 1'b0, 1'b0, '0, '0);
    end
    endTest("field passing");

    $display("Tests %0d, mismatches %0d, assertion failures %0d",
             testCount, errorCount, u_dut.u_chk.failCount);
    if (errorCount == 0 && u_dut.u_chk.failCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
cpuPkg.sv
controlDecoder.sv
registerFile.sv
hazardUnit.sv
idExRegister.sv
decodeStage.sv
decodeStage_chk.sv
decodeStage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= decodeStage_tb
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+100

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
